/* dmaPkg.sv */
package dmaPkg;

  // channel count and bus widths
  localparam int NumChannels = 4;
  localparam int AddrWidth   = 32;
  localparam int DataWidth   = 32;
  localparam int CountWidth  = 14;
  localparam int CtlWidth    = 16;

  // control word layout
  localparam int CtlEnableBit = 15;
  localparam int CtlIrqBit    = 14;
  localparam int CtlTimingLsb = 12;  // 2 bits
  localparam int CtlWordBit   = 10;
  localparam int CtlRepeatBit = 9;
  localparam int CtlSrcLsb    = 7;   // 2 bits
  localparam int CtlDstLsb    = 5;   // 2 bits

  // display timing points used as start triggers
  localparam int HblankDot  = 240;
  localparam int VblankLine = 160;

  typedef enum logic [2:0] {
    Off,
    Idle,
    Queued,     // start seen, waiting for the bus
    Read,
    Write,
    Preempted   // lost the bus to a lower channel between words
  } dmaState;

  typedef enum logic [1:0] {
    AddrInc       = 2'd0,
    AddrDec       = 2'd1,
    AddrFixed     = 2'd2,
    AddrIncReload = 2'd3
  } addrCtl;

  typedef enum logic [1:0] {
    StartNow     = 2'd0,
    StartVblank  = 2'd1,
    StartHblank  = 2'd2,
    StartSpecial = 2'd3
  } startTiming;

  // encoding matches the memory port size field
  typedef enum logic [1:0] {
    SizeHalf = 2'd1,
    SizeWord = 2'd2
  } xferSize;

endpackage

/* dmaChannelFsm.sv */
module dmaChannelFsm
  import dmaPkg::*;
(
  input  logic clk,
  input  logic rst_b,
  input  logic enable,
  input  logic start,
  input  logic repeatMode,
  input  logic irqEnable,
  input  logic memDone,
  input  logic preempted,
  input  logic allowedToBegin,
  input  logic xferDone,
  output logic loadAddr,
  output logic stepSrc,
  output logic stepDst,
  output logic storeData,
  output logic reloadCount,
  output logic active,
  output logic write,
  output logic midWord,
  output logic irq,
  output logic disableDma
);
  dmaState state;
  dmaState nextState;
  logic    canBegin;

  assign canBegin = allowedToBegin & ~preempted;

  // the bus belongs to this channel from its read until its write completes
  assign midWord = (state == Read) || (state == Write);
  assign write   = (state == Write);

  // a pending channel claims the bus too, so higher channels yield after their write
  assign active = midWord || (state == Queued) || (state == Preempted) ||
                  ((state == Idle) && enable && start);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b)
      state <= Off;
    else
      state <= nextState;
  end

  always_comb begin
    nextState   = state;
    loadAddr    = 1'b0;
    stepSrc     = 1'b0;
    stepDst     = 1'b0;
    storeData   = 1'b0;
    reloadCount = 1'b0;
    irq         = 1'b0;
    disableDma  = 1'b0;
    case (state)
      Off: begin
        if (enable) begin
          loadAddr  = 1'b1;
          nextState = Idle;
        end
      end
      Idle: begin
        if (!enable)
          nextState = Off;
        else if (start)
          nextState = canBegin ? Read : Queued;
      end
      Queued, Preempted: begin
        if (!enable)
          nextState = Off;
        else if (canBegin)
          nextState = Read;
      end
      Read: begin
        if (memDone) begin
          storeData = 1'b1;
          stepSrc   = 1'b1;  // also counts the word
          nextState = Write;
        end
      end
      Write: begin
        if (memDone) begin
          stepDst = 1'b1;
          if (xferDone) begin
            irq = irqEnable;
            if (repeatMode) begin
              reloadCount = 1'b1;
              nextState   = Idle;
            end else begin
              disableDma = 1'b1;
              nextState  = Off;
            end
          end else if (preempted) begin
            nextState = Preempted;
          end else begin
            nextState = Read;
          end
        end
      end
      default: nextState = Off;
    endcase
  end

endmodule

/* dmaAddrPath.sv */
module dmaAddrPath
  import dmaPkg::*;
(
  input  logic                  clk,
  input  logic                  rst_b,
  input  logic [AddrWidth-1:0]  srcAddr,
  input  logic [AddrWidth-1:0]  dstAddr,
  input  logic [CountWidth-1:0] wordCount,
  input  addrCtl                srcCtl,
  input  addrCtl                dstCtl,
  input  logic                  wordMode,
  input  logic                  loadAddr,
  input  logic                  stepSrc,
  input  logic                  stepDst,
  input  logic                  storeData,
  input  logic                  reloadCount,
  input  logic                  write,
  input  logic [DataWidth-1:0]  rdata,
  output logic [AddrWidth-1:0]  reqAddr,
  output logic [DataWidth-1:0]  reqWdata,
  output xferSize               reqSize,
  output logic                  xferDone
);
  logic [AddrWidth-1:0] curSrc;
  logic [AddrWidth-1:0] curDst;
  logic [AddrWidth-1:0] stepSize;
  logic [DataWidth-1:0] readData;
  logic [CountWidth:0]  wordsDone;   // one extra bit, a count of 0 means 2^CountWidth
  logic [CountWidth:0]  wordTarget;
  logic                 reloadDst;

  function automatic logic [AddrWidth-1:0] nextAddr(input logic [AddrWidth-1:0] addr,
                                                    input addrCtl ctl,
                                                    input logic [AddrWidth-1:0] step);
    case (ctl)
      AddrDec:   return addr - step;
      AddrFixed: return addr;
      default:   return addr + step;  // inc and inc-reload
    endcase
  endfunction

  assign stepSize  = wordMode ? AddrWidth'(4) : AddrWidth'(2);
  assign reloadDst = reloadCount && (dstCtl == AddrIncReload);

  always_ff @(posedge clk) begin
    if (loadAddr)
      curSrc <= srcAddr;
    else if (stepSrc)
      curSrc <= nextAddr(curSrc, srcCtl, stepSize);

    if (loadAddr || reloadDst)
      curDst <= dstAddr;
    else if (stepDst)
      curDst <= nextAddr(curDst, dstCtl, stepSize);

    if (storeData)
      readData <= rdata;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b)
      wordsDone <= '0;
    else if (loadAddr || reloadCount)
      wordsDone <= '0;
    else if (stepSrc)
      wordsDone <= wordsDone + 1'b1;
  end

  assign wordTarget = (wordCount == '0) ? {1'b1, {CountWidth{1'b0}}} : {1'b0, wordCount};
  assign xferDone   = (wordsDone == wordTarget);

  assign reqAddr = write ? curDst : curSrc;
  assign reqSize = wordMode ? SizeWord : SizeHalf;

  // a halfword going to the upper half of a word rides in the upper lane
  always_comb begin
    reqWdata = readData;
    if (!wordMode && curDst[1])
      reqWdata[DataWidth-1 -: DataWidth/2] = readData[DataWidth/2-1:0];
  end

endmodule

/* dmaStartTrigger.sv */
module dmaStartTrigger
  import dmaPkg::*;
(
  input  startTiming  timing,
  input  logic [15:0] hcount,
  input  logic [15:0] vcount,
  input  logic        cpuPreemptable,
  output logic        start
);
  logic timingHit;

  // only the low byte of each counter is compared
  always_comb begin
    case (timing)
      StartNow:    timingHit = 1'b1;
      StartVblank: timingHit = (vcount[7:0] == 8'(VblankLine));
      StartHblank: timingHit = (hcount[7:0] == 8'(HblankDot));
      default:     timingHit = 1'b0;  // special timing never fires
    endcase
  end

  // cpu must be at a point where the bus can be taken
  assign start = timingHit & cpuPreemptable;

endmodule

/* dmaPriority.sv */
module dmaPriority
  import dmaPkg::*;
(
  input  logic [NumChannels-1:0] active,
  input  logic [NumChannels-1:0] midWord,
  input  logic [AddrWidth-1:0]   reqAddr [NumChannels],
  input  logic [DataWidth-1:0]   reqWdata [NumChannels],
  input  xferSize                reqSize [NumChannels],
  input  logic [NumChannels-1:0] reqWrite,
  output logic [NumChannels-1:0] preempted,
  output logic                   allowedToBegin,
  output logic                   memValid,
  output logic [AddrWidth-1:0]   memAddr,
  output logic                   memWrite,
  output logic [DataWidth-1:0]   memWdata,
  output xferSize                memSize,
  output logic                   busActive
);

  // lower index wins, so each channel yields to any active channel below it
  always_comb begin
    logic lowerActive;
    lowerActive = 1'b0;
    for (int i = 0; i < NumChannels; i++) begin
      preempted[i] = lowerActive;
      lowerActive  = lowerActive | active[i];
    end
  end

  assign allowedToBegin = ~|midWord;  // nobody starts while a word is in flight
  assign busActive      = |active;

  // only the channel holding the bus has a request out
  assign memValid = |midWord;

  always_comb begin
    memAddr  = '0;
    memWrite = 1'b0;
    memWdata = '0;
    memSize  = SizeWord;
    for (int i = NumChannels - 1; i >= 0; i--) begin
      if (midWord[i]) begin
        memAddr  = reqAddr[i];
        memWrite = reqWrite[i];
        memWdata = reqWdata[i];
        memSize  = reqSize[i];
      end
    end
  end

endmodule

/* dmaTop.sv */
module dmaTop
  import dmaPkg::*;
(
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic [AddrWidth-1:0]   srcAddr [NumChannels],
  input  logic [AddrWidth-1:0]   dstAddr [NumChannels],
  input  logic [CountWidth-1:0]  wordCount [NumChannels],
  input  logic [CtlWidth-1:0]    control [NumChannels],
  input  logic [15:0]            hcount,
  input  logic [15:0]            vcount,
  input  logic                   cpuPreemptable,
  input  logic                   memReady,
  input  logic [DataWidth-1:0]   rdata,
  output logic                   memValid,
  output logic [AddrWidth-1:0]   memAddr,
  output logic                   memWrite,
  output logic [DataWidth-1:0]   memWdata,
  output xferSize                memSize,
  output logic                   busActive,
  output logic [NumChannels-1:0] irq,
  output logic [NumChannels-1:0] disableDma
);
  logic [NumChannels-1:0] active;
  logic [NumChannels-1:0] midWord;
  logic [NumChannels-1:0] chanWrite;
  logic [NumChannels-1:0] preempted;
  logic [NumChannels-1:0] memDone;
  logic                   allowedToBegin;
  logic [AddrWidth-1:0]   reqAddr [NumChannels];
  logic [DataWidth-1:0]   reqWdata [NumChannels];
  xferSize                reqSize [NumChannels];

  for (genvar i = 0; i < NumChannels; i++) begin : gChan
    logic start;
    logic loadAddr;
    logic stepSrc;
    logic stepDst;
    logic storeData;
    logic reloadCount;
    logic xferDone;

    assign memDone[i] = memValid & memReady & midWord[i];  // handshake seen by the owner

    dmaStartTrigger u_trigger (
      .timing        (startTiming'(control[i][CtlTimingLsb +: 2])),
      .hcount        (hcount),
      .vcount        (vcount),
      .cpuPreemptable(cpuPreemptable),
      .start         (start)
    );

    dmaChannelFsm u_fsm (
      .clk           (clk),
      .rst_b         (rst_b),
      .enable        (control[i][CtlEnableBit]),
      .start         (start),
      .repeatMode    (control[i][CtlRepeatBit]),
      .irqEnable     (control[i][CtlIrqBit]),
      .memDone       (memDone[i]),
      .preempted     (preempted[i]),
      .allowedToBegin(allowedToBegin),
      .xferDone      (xferDone),
      .loadAddr      (loadAddr),
      .stepSrc       (stepSrc),
      .stepDst       (stepDst),
      .storeData     (storeData),
      .reloadCount   (reloadCount),
      .active        (active[i]),
      .write         (chanWrite[i]),
      .midWord       (midWord[i]),
      .irq           (irq[i]),
      .disableDma    (disableDma[i])
    );

    dmaAddrPath u_addr (
      .clk        (clk),
      .rst_b      (rst_b),
      .srcAddr    (srcAddr[i]),
      .dstAddr    (dstAddr[i]),
      .wordCount  (wordCount[i]),
      .srcCtl     (addrCtl'(control[i][CtlSrcLsb +: 2])),
      .dstCtl     (addrCtl'(control[i][CtlDstLsb +: 2])),
      .wordMode   (control[i][CtlWordBit]),
      .loadAddr   (loadAddr),
      .stepSrc    (stepSrc),
      .stepDst    (stepDst),
      .storeData  (storeData),
      .reloadCount(reloadCount),
      .write      (chanWrite[i]),
      .rdata      (rdata),
      .reqAddr    (reqAddr[i]),
      .reqWdata   (reqWdata[i]),
      .reqSize    (reqSize[i]),
      .xferDone   (xferDone)
    );
  end

  dmaPriority u_priority (
    .active        (active),
    .midWord       (midWord),
    .reqAddr       (reqAddr),
    .reqWdata      (reqWdata),
    .reqSize       (reqSize),
    .reqWrite      (chanWrite),
    .preempted     (preempted),
    .allowedToBegin(allowedToBegin),
    .memValid      (memValid),
    .memAddr       (memAddr),
    .memWrite      (memWrite),
    .memWdata      (memWdata),
    .memSize       (memSize),
    .busActive     (busActive)
  );

endmodule

/* dma_asserts.sv */
module dmaAsserts
  import dmaPkg::*;
(
  input logic                   clk,
  input logic                   rst_b,
  input logic                   memValid,
  input logic                   memReady,
  input logic [AddrWidth-1:0]   memAddr,
  input logic                   memWrite,
  input logic [DataWidth-1:0]   memWdata,
  input xferSize                memSize,
  input logic                   busActive,
  input logic [NumChannels-1:0] active,
  input logic [NumChannels-1:0] midWord
);
  int failCount = 0;

  // request holds while the memory stalls
  assert property (@(posedge clk) disable iff (!rst_b)
    memValid && !memReady |=> memValid && $stable(memAddr) && $stable(memWrite) &&
                              $stable(memWdata) && $stable(memSize))
  else begin
    failCount++;
    $error("memory request changed under back-pressure");
  end

  assert property (@(posedge clk) !rst_b |=> !busActive && !memValid)
  else begin
    failCount++;
    $error("bus active during or right after reset");
  end

  assert property (@(posedge clk) disable iff (!rst_b) $onehot0(midWord))
  else begin
    failCount++;
    $error("more than one channel holds the bus");
  end

  // a read is always followed by the write of the same channel
  assert property (@(posedge clk) disable iff (!rst_b)
    memValid && memReady && !memWrite |=> memWrite && midWord == $past(midWord))
  else begin
    failCount++;
    $error("word split between channels");
  end

  for (genvar i = 1; i < NumChannels; i++) begin : gBegin
    assert property (@(posedge clk) disable iff (!rst_b)
      $rose(midWord[i]) |-> ($past(active) & NumChannels'((1 << i) - 1)) == '0)
    else begin
      failCount++;
      $error("channel %0d began while a lower channel was pending", i);
    end

    // a lower channel waiting takes the bus at the next word boundary
    assert property (@(posedge clk) disable iff (!rst_b)
      memValid && memReady && memWrite && midWord[i] &&
      (active & NumChannels'((1 << i) - 1)) != '0 |=> !midWord[i])
    else begin
      failCount++;
      $error("channel %0d kept the bus after a lower channel asked for it", i);
    end
  end

endmodule

bind dmaTop dmaAsserts u_asserts (
  .clk      (clk),
  .rst_b    (rst_b),
  .memValid (memValid),
  .memReady (memReady),
  .memAddr  (memAddr),
  .memWrite (memWrite),
  .memWdata (memWdata),
  .memSize  (memSize),
  .busActive(busActive),
  .active   (active),
  .midWord  (midWord)
);

/* dmaChecker.sv */
module dmaChecker
  import dmaPkg::*;
(
  input logic                   clk,
  input logic                   rst_b,
  input logic                   memValid,
  input logic                   memReady,
  input logic                   memWrite,
  input logic [AddrWidth-1:0]   memAddr,
  input logic [DataWidth-1:0]   memWdata,
  input xferSize                memSize,
  input logic [NumChannels-1:0] owner,
  input logic [NumChannels-1:0] irq,
  input logic [NumChannels-1:0] disableDma,
  input logic [15:0]            hcount,
  input logic [15:0]            vcount,
  input logic                   cpuPreemptable
);
  localparam int EntryMsb = 2 + AddrWidth + DataWidth;

  // {write, size, addr, data} per expected access
  logic [EntryMsb:0] expQ [NumChannels][$];
  int                errors     = 0;
  int                writeCount = 0;
  int                irqSeen [NumChannels] = '{default: 0};
  int                disSeen [NumChannels] = '{default: 0};
  int                irqExp [NumChannels]  = '{default: 0};
  int                disExp [NumChannels]  = '{default: 0};
  startTiming        rowTiming = StartNow;
  logic              startSeen = 1'b1;

  task automatic startRow(input startTiming t);
    rowTiming  = t;
    startSeen  = (t == StartNow);
    writeCount = 0;
  endtask

  task automatic pushAccess(input int c, input logic wr, input xferSize sz,
                            input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] d);
    expQ[c].push_back({wr, sz, a, d});
  endtask

  task automatic expectPulses(input int c, input int irqs, input int dis);
    irqExp[c] += irqs;
    disExp[c] += dis;
  endtask

  function automatic int pendingCount();
    int n;
    n = 0;
    for (int c = 0; c < NumChannels; c++)
      n += expQ[c].size();
    return n;
  endfunction

  task automatic endRow();
    for (int c = 0; c < NumChannels; c++) begin
      if (expQ[c].size() != 0) begin
        errors++;
        $display("channel %0d never made %0d expected accesses", c, expQ[c].size());
        expQ[c].delete();
      end
      if (irqSeen[c] != irqExp[c] || disSeen[c] != disExp[c]) begin
        errors++;
        $display("error %0t: channel %0d irq %0d disable %0d, expected irq %0d disable %0d",
                 $time, c, irqSeen[c], disSeen[c], irqExp[c], disExp[c]);
      end
      irqSeen[c] = 0;
      disSeen[c] = 0;
      irqExp[c]  = 0;
      disExp[c]  = 0;
    end
  endtask

  always @(posedge clk) begin
    logic [EntryMsb:0]    e;
    logic [DataWidth-1:0] expData;
    logic [15:0]          gotHalf;
    int                   ch;
    if (rst_b) begin
      if (memValid && !startSeen) begin
        errors++;
        $display("error %0t: bus request at line %0d dot %0d before its start condition",
                 $time, vcount, hcount);
      end
      if (cpuPreemptable &&
          ((rowTiming == StartHblank && hcount[7:0] == 8'(HblankDot)) ||
           (rowTiming == StartVblank && vcount[7:0] == 8'(VblankLine))))
        startSeen = 1'b1;

      if (memValid && memReady) begin
        ch = -1;
        for (int i = 0; i < NumChannels; i++)
          if (owner[i])
            ch = i;
        if (ch < 0) begin
          errors++;
          $display("memory handshake at time %0t with no channel holding the bus", $time);
        end else if (expQ[ch].size() == 0) begin
          errors++;
          $display("channel %0d made an unexpected access at time %0t", ch, $time);
        end else begin
          e       = expQ[ch].pop_front();
          expData = e[DataWidth-1:0];
          if (memWrite !== e[EntryMsb] || memAddr !== e[DataWidth +: AddrWidth] ||
              memSize !== e[AddrWidth + DataWidth +: 2]) begin
            errors++;
            $display("error %0t: ch%0d write=%0b addr=%h size=%0d, expected write=%0b addr=%h",
                     $time, ch, memWrite, memAddr, memSize, e[EntryMsb],
                     e[DataWidth +: AddrWidth]);
          end else if (memWrite) begin
            if (memSize == SizeHalf) begin
              gotHalf = memAddr[1] ? memWdata[31:16] : memWdata[15:0];  // lane from addr bit 1
              if (gotHalf !== expData[15:0]) begin
                errors++;
                $display("error %0t: ch%0d halfword %h at %h, expected %h", $time, ch,
                         gotHalf, memAddr, expData[15:0]);
              end
            end else if (memWdata !== expData) begin
              errors++;
              $display("error %0t: ch%0d word %h at %h, expected %h", $time, ch, memWdata,
                       memAddr, expData);
            end
          end
        end
        if (memWrite)
          writeCount++;
      end

      for (int c = 0; c < NumChannels; c++) begin
        if ((irq[c] || disableDma[c]) && !(memValid && memReady && memWrite && owner[c])) begin
          errors++;
          $display("error %0t: ch%0d completion pulse outside its write handshake", $time, c);
        end
        if (irq[c]) begin
          irqSeen[c]++;
          if (rowTiming != StartNow)
            startSeen = 1'b0;  // a repeat pass waits for the next trigger
        end
        if (disableDma[c])
          disSeen[c]++;
      end
    end
  end

endmodule

/* dmaTb.sv */
module dmaTb
  import dmaPkg::*;
();
  localparam int NumRows    = 7;
  localparam int LineDots   = 300;
  localparam int FrameLines = 228;
  localparam int NoChannel  = 4;

  typedef struct packed {
    logic [1:0]            chan;
    logic [AddrWidth-1:0]  src;
    logic [AddrWidth-1:0]  dst;
    logic [CountWidth-1:0] count;
    addrCtl                srcCtl;
    addrCtl                dstCtl;
    logic                  wordMode;
    startTiming            timing;
    logic                  rpt;
    logic                  irqEn;
    logic [2:0]            chan2;   // second channel, NoChannel for none
    logic [3:0]            delay2;  // writes seen before the second channel is enabled
  } rowT;

  logic                   clk;
  logic                   rst_b;
  logic [AddrWidth-1:0]   srcAddr [NumChannels];
  logic [AddrWidth-1:0]   dstAddr [NumChannels];
  logic [CountWidth-1:0]  wordCount [NumChannels];
  logic [CtlWidth-1:0]    control [NumChannels];
  logic [15:0]            hcount;
  logic [15:0]            vcount;
  logic                   cpuPreemptable;
  logic                   memReady;
  logic [DataWidth-1:0]   rdata;
  logic                   memValid;
  logic [AddrWidth-1:0]   memAddr;
  logic                   memWrite;
  logic [DataWidth-1:0]   memWdata;
  xferSize                memSize;
  logic                   busActive;
  logic [NumChannels-1:0] irq;
  logic [NumChannels-1:0] disableDma;

  logic        frameRestart;
  logic        timedRow;
  logic [1:0]  waitLeft;
  logic [31:0] lfsr = 32'hb1fe5549;
  rowT         rows [NumRows];

  dmaTop u_dmaTop (.*);

  dmaChecker u_checker (
    .clk           (clk),
    .rst_b         (rst_b),
    .memValid      (memValid),
    .memReady      (memReady),
    .memWrite      (memWrite),
    .memAddr       (memAddr),
    .memWdata      (memWdata),
    .memSize       (memSize),
    .owner         (u_dmaTop.midWord),
    .irq           (irq),
    .disableDma    (disableDma),
    .hcount        (hcount),
    .vcount        (vcount),
    .cpuPreemptable(cpuPreemptable)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois lfsr, one step per bit
  function automatic logic [1:0] nextLatency();
    logic [1:0] v;
    for (int i = 0; i < 2; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [DataWidth-1:0] readValue(input logic [AddrWidth-1:0] a,
                                                     input xferSize sz);
    logic [DataWidth-1:0] d;
    d = (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
    if (sz == SizeHalf)
      d = {~d[15:0], d[15:0]};  // halfword comes back in the low lane only
    return d;
  endfunction

  function automatic logic [AddrWidth-1:0] stepAddr(input logic [AddrWidth-1:0] a,
                                                    input addrCtl ctl, input logic word);
    logic [AddrWidth-1:0] step;
    step = word ? 32'd4 : 32'd2;
    if (ctl == AddrDec)
      return a - step;
    if (ctl == AddrFixed)
      return a;
    return a + step;
  endfunction

  function automatic logic [CtlWidth-1:0] ctlWord(input logic irqEn, input startTiming t,
                                                  input logic word, input logic rpt,
                                                  input addrCtl s, input addrCtl d);
    logic [CtlWidth-1:0] w;
    w = '0;
    w[CtlEnableBit]      = 1'b1;
    w[CtlIrqBit]         = irqEn;
    w[CtlTimingLsb +: 2] = t;
    w[CtlWordBit]        = word;
    w[CtlRepeatBit]      = rpt;
    w[CtlSrcLsb +: 2]    = s;
    w[CtlDstLsb +: 2]    = d;
    return w;
  endfunction

  task automatic pushTransfer(input int c, input logic [AddrWidth-1:0] src,
                              input logic [AddrWidth-1:0] dst, input int count,
                              input addrCtl sCtl, input addrCtl dCtl, input logic word,
                              input int passes);
    logic [AddrWidth-1:0] s;
    logic [AddrWidth-1:0] d;
    xferSize              sz;
    s  = src;
    d  = dst;
    sz = word ? SizeWord : SizeHalf;
    for (int p = 0; p < passes; p++) begin
      if (dCtl == AddrIncReload)
        d = dst;
      for (int k = 0; k < count; k++) begin
        u_checker.pushAccess(c, 1'b0, sz, s, '0);
        u_checker.pushAccess(c, 1'b1, sz, d, readValue(s, sz));
        s = stepAddr(s, sCtl, word);
        d = stepAddr(d, dCtl, word);
      end
    end
  endtask

  // memory model with 0 to 3 wait cycles per access
  always @(posedge clk) begin
    if (!rst_b) begin
      memReady <= 1'b0;
      waitLeft <= nextLatency();
    end else if (memValid && memReady) begin
      memReady <= 1'b0;
      waitLeft <= nextLatency();
    end else if (memValid) begin
      if (waitLeft == 2'd0) begin
        memReady <= 1'b1;
        rdata    <= readValue(memAddr, memSize);
      end else begin
        waitLeft <= waitLeft - 2'd1;
      end
    end
  end

  // display counters; line 150 keeps the cpu busy on timed rows
  always @(posedge clk) begin
    if (frameRestart) begin
      hcount <= 16'd0;
      vcount <= 16'd150;
    end else if (hcount == LineDots - 1) begin
      hcount <= 16'd0;
      vcount <= (vcount == FrameLines - 1) ? 16'd0 : vcount + 16'd1;
    end else begin
      hcount <= hcount + 16'd1;
    end
    cpuPreemptable <= !(timedRow && vcount == 16'd150);
  end

  // one-shot channels are switched off once they report done
  always @(posedge clk) begin
    for (int c = 0; c < NumChannels; c++)
      if (disableDma[c])
        control[c][CtlEnableBit] <= 1'b0;
  end

  initial begin
    rowT row;
    int  waited;
    int  timeouts;
    int  total;
    timeouts       = 0;
    rst_b          = 1'b0;
    hcount         = 16'd0;
    vcount         = 16'd0;
    cpuPreemptable = 1'b1;
    rdata          = '0;
    memReady       = 1'b0;
    frameRestart   = 1'b0;
    timedRow       = 1'b0;
    for (int c = 0; c < NumChannels; c++) begin
      srcAddr[c]   = '0;
      dstAddr[c]   = '0;
      wordCount[c] = '0;
      control[c]   = '0;
    end
    rows[0] = '{2'd0, 32'h0200_0000, 32'h0300_0000, 14'd5, AddrInc, AddrInc, 1'b1, StartNow,
                1'b0, 1'b1, 3'd4, 4'd0};
    rows[1] = '{2'd1, 32'h0200_0106, 32'h0300_0402, 14'd4, AddrDec, AddrFixed, 1'b0, StartNow,
                1'b0, 1'b0, 3'd4, 4'd0};
    rows[2] = '{2'd3, 32'h0200_0300, 32'h0300_0800, 14'd4, AddrInc, AddrInc, 1'b0, StartHblank,
                1'b0, 1'b1, 3'd4, 4'd0};
    rows[3] = '{2'd2, 32'h0200_0400, 32'h0300_0c00, 14'd3, AddrInc, AddrDec, 1'b1, StartVblank,
                1'b0, 1'b1, 3'd4, 4'd0};
    rows[4] = '{2'd3, 32'h0200_0500, 32'h0300_1000, 14'd4, AddrInc, AddrInc, 1'b1, StartNow,
                1'b0, 1'b0, 3'd1, 4'd0};
    rows[5] = '{2'd2, 32'h0200_0600, 32'h0300_1400, 14'd6, AddrInc, AddrInc, 1'b1, StartNow,
                1'b0, 1'b1, 3'd0, 4'd2};
    rows[6] = '{2'd1, 32'h0200_0700, 32'h0300_1800, 14'd2, AddrInc, AddrIncReload, 1'b1,
                StartHblank, 1'b1, 1'b1, 3'd4, 4'd0};
    repeat (8) @(posedge clk);
    rst_b <= 1'b1;

    for (int r = 0; r < NumRows; r++) begin
      row = rows[r];
      @(posedge clk);
      frameRestart <= 1'b1;
      timedRow     <= (row.timing != StartNow);
      @(posedge clk);
      frameRestart <= 1'b0;
      @(posedge clk);
      u_checker.startRow(row.timing);
      pushTransfer(row.chan, row.src, row.dst, row.count, row.srcCtl, row.dstCtl,
                   row.wordMode, row.rpt ? 2 : 1);
      u_checker.expectPulses(row.chan, row.irqEn ? (row.rpt ? 2 : 1) : 0, row.rpt ? 0 : 1);
      srcAddr[row.chan]   <= row.src;
      dstAddr[row.chan]   <= row.dst;
      wordCount[row.chan] <= row.count;
      control[row.chan]   <= ctlWord(row.irqEn, row.timing, row.wordMode, row.rpt,
                                     row.srcCtl, row.dstCtl);
      if (row.chan2 != NoChannel) begin
        pushTransfer(row.chan2, row.src + 32'h80, row.dst + 32'h80, 3, AddrInc, AddrInc,
                     1'b1, 1);
        u_checker.expectPulses(row.chan2, 1, 1);
        srcAddr[row.chan2]   <= row.src + 32'h80;
        dstAddr[row.chan2]   <= row.dst + 32'h80;
        wordCount[row.chan2] <= 14'd3;
        waited = 0;
        while (u_checker.writeCount < row.delay2 && waited < 2000) begin
          @(posedge clk);
          waited++;
        end
        if (waited >= 2000) begin
          $display("timeout: row %0d never reached the point to enable its second channel", r);
          timeouts++;
        end
        control[row.chan2] <= ctlWord(1'b1, StartNow, 1'b1, 1'b0, AddrInc, AddrInc);
      end

      waited = 0;
      while (u_checker.pendingCount() != 0 && waited < 20000) begin
        @(posedge clk);
        waited++;
      end
      if (waited >= 20000) begin
        $display("timeout: row %0d did not finish its transfers", r);
        timeouts++;
      end
      if (row.rpt)
        control[row.chan][CtlEnableBit] <= 1'b0;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
      end while ((busActive || memValid) && waited < 100);
      if (waited >= 100) begin
        $display("timeout: bus still busy after row %0d", r);
        timeouts++;
      end
      u_checker.endRow();
    end

    total = u_checker.errors + u_dmaTop.u_asserts.failCount + timeouts;
    $display("errors: %0d compare, %0d assertion, %0d timeout", u_checker.errors,
             u_dmaTop.u_asserts.failCount, timeouts);
    if (total == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* files.f */
dmaPkg.sv
dmaChannelFsm.sv
dmaAddrPath.sv
dmaStartTrigger.sv
dmaPriority.sv
dmaTop.sv
dma_asserts.sv
dmaChecker.sv
dmaTb.sv

/* Bender.yml */
package:
  name: dma

sources:
  - dmaPkg.sv
  - dmaChannelFsm.sv
  - dmaAddrPath.sv
  - dmaStartTrigger.sv
  - dmaPriority.sv
  - dmaTop.sv
  - target: test
    files:
      - dma_asserts.sv
      - dmaChecker.sv
      - dmaTb.sv
